//--- rtl/backend_pkg.sv
package backend_pkg;

	localparam int XLEN      = 64;
	localparam int AREG_AW   = 5;
	localparam int ROB_DEPTH = 8;
	localparam int ROB_AW    = 3;
	localparam int ISSUE_DP  = 4;

	// add/sub go to the adder lane, the rest to logic/compare
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_SLTU = 3'd6
	} op_e;

	// word popped from the instruction fifo
	typedef struct packed {
		op_e                op;
		logic [AREG_AW-1:0] rd;
		logic [AREG_AW-1:0] rs1;
		logic [AREG_AW-1:0] rs2;
		logic               use_imm;
		logic [15:0]        imm;
	} micro_instr_t;

	// issue fifo entry, operands already resolved
	typedef struct packed {
		op_e               op;
		logic [ROB_AW-1:0] tag;
		logic [XLEN-1:0]   src1;
		logic [XLEN-1:0]   src2;
	} exe_param_t;

	typedef struct packed {
		logic              valid;
		logic [ROB_AW-1:0] tag;
		logic [XLEN-1:0]   result;
	} wb_t;

	typedef struct packed {
		logic [ROB_AW-1:0]  tag;
		logic [AREG_AW-1:0] rd;
	} rob_alloc_t;

	typedef struct packed {
		logic [AREG_AW-1:0] rd;
		logic [XLEN-1:0]    data;
	} commit_t;

endpackage

//--- rtl/dispatch.sv
`timescale 1ns/1ns

module dispatch import backend_pkg::*; (
	input  logic                    CLK,
	input  logic                    i_rst_n,
	input  micro_instr_t            i_instr,
	input  logic                    i_instr_empty,
	input  logic                    i_add_full,
	input  logic                    i_lc_full,
	input  logic                    i_rob_full,
	input  logic [ROB_AW-1:0]       i_rob_tail,
	input  logic [2**AREG_AW-1:0]   i_busy,
	input  logic [XLEN-1:0]         i_rs1_data,
	input  logic [XLEN-1:0]         i_rs2_data,
	output logic                    o_instr_pop,
	output logic                    o_add_push,
	output logic                    o_lc_push,
	output exe_param_t              o_exe_param,
	output logic                    o_rob_alloc_valid,
	output rob_alloc_t              o_rob_alloc,
	output logic [AREG_AW-1:0]      o_rs1,
	output logic [AREG_AW-1:0]      o_rs2
);

	logic            add_sel;
	logic            lane_full;
	logic            hazard;
	logic            fire;
	logic [XLEN-1:0] src2;

	assign add_sel   = (i_instr.op == OP_ADD) || (i_instr.op == OP_SUB);
	assign lane_full = add_sel ? i_add_full : i_lc_full;

	// RAW on used sources, WAW on rd
	assign hazard = i_busy[i_instr.rs1] |
		(!i_instr.use_imm & i_busy[i_instr.rs2]) |
		i_busy[i_instr.rd];

	assign fire = !i_instr_empty && !i_rob_full && !lane_full && !hazard;

	assign o_rs1 = i_instr.rs1;
	assign o_rs2 = i_instr.rs2;

	// imm is sign extended to the full word
	assign src2 = i_instr.use_imm ? {{(XLEN-16){i_instr.imm[15]}}, i_instr.imm} : i_rs2_data;

	assign o_instr_pop       = fire;
	assign o_rob_alloc_valid = fire;
	assign o_add_push        = fire & add_sel;
	assign o_lc_push         = fire & !add_sel;

	assign o_exe_param = '{op: i_instr.op, tag: i_rob_tail, src1: i_rs1_data, src2: src2};
	assign o_rob_alloc = '{tag: i_rob_tail, rd: i_instr.rd};

	// an undefined opcode would silently land in the logic/compare lane
	a_legal_op: assert property (@(posedge CLK) disable iff (!i_rst_n)
		o_instr_pop |-> (i_instr.op inside
			{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU}));

endmodule

//--- rtl/issue_fifo.sv
`timescale 1ns/1ns

module issue_fifo import backend_pkg::*; #(
	parameter int DP = ISSUE_DP
) (
	input  logic       CLK,
	input  logic       i_rst_n,
	input  logic       i_push,
	input  exe_param_t i_data,
	input  logic       i_pop,
	output exe_param_t o_data,
	output logic       o_full,
	output logic       o_empty
);

	exe_param_t             mem [DP];
	logic [$clog2(DP)-1:0]  wr_ptr;
	logic [$clog2(DP)-1:0]  rd_ptr;
	logic [$clog2(DP):0]    count;

	assign o_data  = mem[rd_ptr];
	assign o_full  = (count == ($clog2(DP)+1)'(DP));
	assign o_empty = (count == '0);

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == DP-1) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == DP-1) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + ($clog2(DP)+1)'(i_push) - ($clog2(DP)+1)'(i_pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	a_no_pop_empty: assert property (@(posedge CLK) disable iff (!i_rst_n) i_pop |-> !o_empty);
	a_no_push_full: assert property (@(posedge CLK) disable iff (!i_rst_n) i_push |-> !o_full);

endmodule

//--- rtl/adder_unit.sv
`timescale 1ns/1ns

module adder_unit import backend_pkg::*; (
	input  logic       CLK,
	input  logic       i_rst_n,
	input  logic       i_empty,
	input  exe_param_t i_param,
	output logic       o_pop,
	output wb_t        o_wb
);

	logic              wb_valid;
	logic [ROB_AW-1:0] wb_tag;
	logic [XLEN-1:0]   wb_res;

	// always ready, take the head as soon as it shows up
	assign o_pop = !i_empty;

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= o_pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_pop) begin
			wb_tag <= i_param.tag;
			wb_res <= (i_param.op == OP_SUB) ? i_param.src1 - i_param.src2
				: i_param.src1 + i_param.src2;
		end
	end

	assign o_wb = '{valid: wb_valid, tag: wb_tag, result: wb_res};

	a_add_op: assert property (@(posedge CLK) disable iff (!i_rst_n)
		o_pop |-> (i_param.op inside {OP_ADD, OP_SUB}));

endmodule

//--- rtl/logcmp_unit.sv
`timescale 1ns/1ns

module logcmp_unit import backend_pkg::*; (
	input  logic       CLK,
	input  logic       i_rst_n,
	input  logic       i_empty,
	input  exe_param_t i_param,
	output logic       o_pop,
	output wb_t        o_wb
);

	logic              s1_valid;
	op_e               s1_op;
	logic [ROB_AW-1:0] s1_tag;
	logic [XLEN-1:0]   s1_bits;
	logic              s1_lt;
	logic              s1_ltu;
	logic              wb_valid;
	logic [ROB_AW-1:0] wb_tag;
	logic [XLEN-1:0]   wb_res;

	assign o_pop = !i_empty;

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			s1_valid <= o_pop;
			wb_valid <= s1_valid;
		end
	end

	// stage 1
	always_ff @(posedge CLK) begin
		if (o_pop) begin
			s1_op  <= i_param.op;
			s1_tag <= i_param.tag;
			s1_lt  <= $signed(i_param.src1) < $signed(i_param.src2);
			s1_ltu <= i_param.src1 < i_param.src2;
			case (i_param.op)
				OP_AND:  s1_bits <= i_param.src1 & i_param.src2;
				OP_OR:   s1_bits <= i_param.src1 | i_param.src2;
				OP_XOR:  s1_bits <= i_param.src1 ^ i_param.src2;
				default: s1_bits <= '0;
			endcase
		end
	end

	// stage 2, compare flags widened to a full word
	always_ff @(posedge CLK) begin
		if (s1_valid) begin
			wb_tag <= s1_tag;
			case (s1_op)
				OP_SLT:  wb_res <= {{(XLEN-1){1'b0}}, s1_lt};
				OP_SLTU: wb_res <= {{(XLEN-1){1'b0}}, s1_ltu};
				default: wb_res <= s1_bits;
			endcase
		end
	end

	assign o_wb = '{valid: wb_valid, tag: wb_tag, result: wb_res};

endmodule

//--- rtl/writeback_commit.sv
`timescale 1ns/1ns

module writeback_commit import backend_pkg::*; (
	input  logic                  CLK,
	input  logic                  i_rst_n,
	input  logic                  i_rob_alloc_valid,
	input  rob_alloc_t            i_rob_alloc,
	input  logic [AREG_AW-1:0]    i_rs1,
	input  logic [AREG_AW-1:0]    i_rs2,
	input  wb_t                   i_add_wb,
	input  wb_t                   i_lc_wb,
	output logic                  o_rob_full,
	output logic [ROB_AW-1:0]     o_rob_tail,
	output logic [XLEN-1:0]       o_rs1_data,
	output logic [XLEN-1:0]       o_rs2_data,
	output logic [2**AREG_AW-1:0] o_busy,
	output logic                  o_commit_valid,
	output commit_t               o_commit
);

	logic [ROB_DEPTH-1:0]    rob_valid;
	logic [ROB_DEPTH-1:0]    rob_done;
	logic [AREG_AW-1:0]      rob_rd  [ROB_DEPTH];
	logic [XLEN-1:0]         rob_val [ROB_DEPTH];
	logic [ROB_AW-1:0]       head;
	logic [ROB_AW-1:0]       tail;
	logic [ROB_AW:0]         count;
	logic [XLEN-1:0]         regs [2**AREG_AW];
	logic [2**AREG_AW-1:0]   busy;
	logic [2**AREG_AW-1:0]   busy_set;
	logic [2**AREG_AW-1:0]   busy_clr;
	logic                    retire;

	assign retire     = rob_valid[head] & rob_done[head];
	assign o_rob_full = (count == (ROB_AW+1)'(ROB_DEPTH));
	assign o_rob_tail = tail;
	assign o_busy     = busy;

	// x0 is never written, so it reads zero
	assign o_rs1_data = regs[i_rs1];
	assign o_rs2_data = regs[i_rs2];

	always_comb begin
		busy_set = '0;
		busy_clr = '0;
		if (i_rob_alloc_valid && i_rob_alloc.rd != '0) begin
			busy_set[i_rob_alloc.rd] = 1'b1;
		end
		if (retire) begin
			busy_clr[rob_rd[head]] = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rob_valid      <= '0;
			rob_done       <= '0;
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			busy           <= '0;
			o_commit_valid <= 1'b0;
		end else begin
			if (i_rob_alloc_valid) begin
				rob_valid[tail] <= 1'b1;
				rob_done[tail]  <= 1'b0;
				tail            <= tail + 1'b1;
			end
			// both lanes can land in the same cycle
			if (i_add_wb.valid) begin
				rob_done[i_add_wb.tag] <= 1'b1;
			end
			if (i_lc_wb.valid) begin
				rob_done[i_lc_wb.tag] <= 1'b1;
			end
			if (retire) begin
				rob_valid[head] <= 1'b0;
				head            <= head + 1'b1;
			end
			count          <= count + (ROB_AW+1)'(i_rob_alloc_valid) - (ROB_AW+1)'(retire);
			busy           <= (busy & ~busy_clr) | busy_set;
			o_commit_valid <= retire;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_rob_alloc_valid) begin
			rob_rd[tail] <= i_rob_alloc.rd;
		end
		if (i_add_wb.valid) begin
			rob_val[i_add_wb.tag] <= i_add_wb.result;
		end
		if (i_lc_wb.valid) begin
			rob_val[i_lc_wb.tag] <= i_lc_wb.result;
		end
		if (retire) begin
			o_commit <= '{rd: rob_rd[head], data: rob_val[head]};
		end
	end

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 2**AREG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (retire && rob_rd[head] != '0) begin
			regs[rob_rd[head]] <= rob_val[head];
		end
	end

	// dispatch must hand back the tag we advertised
	a_alloc_tag: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_rob_alloc_valid |-> (i_rob_alloc.tag == tail));

	a_add_wb_live: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_add_wb.valid |-> (rob_valid[i_add_wb.tag] && !rob_done[i_add_wb.tag]));

	a_lc_wb_live: assert property (@(posedge CLK) disable iff (!i_rst_n)
		i_lc_wb.valid |-> (rob_valid[i_lc_wb.tag] && !rob_done[i_lc_wb.tag]));

endmodule

//--- rtl/back_end.sv
`timescale 1ns/1ns

module back_end import backend_pkg::*; (
	input  logic         CLK,
	input  logic         i_rst_n,
	input  micro_instr_t i_instr,
	input  logic         i_instr_empty,
	output logic         o_instr_pop,
	output logic         o_commit_valid,
	output commit_t      o_commit
);

	exe_param_t            exe_param;
	logic                  add_push;
	logic                  add_full;
	logic                  add_empty;
	logic                  add_pop;
	exe_param_t            add_head;
	logic                  lc_push;
	logic                  lc_full;
	logic                  lc_empty;
	logic                  lc_pop;
	exe_param_t            lc_head;
	wb_t                   add_wb;
	wb_t                   lc_wb;
	logic                  rob_alloc_valid;
	rob_alloc_t            rob_alloc;
	logic                  rob_full;
	logic [ROB_AW-1:0]     rob_tail;
	logic [AREG_AW-1:0]    rs1;
	logic [AREG_AW-1:0]    rs2;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic [2**AREG_AW-1:0] busy;

	dispatch u_dispatch (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_instr(i_instr), .i_instr_empty(i_instr_empty),
		.i_add_full(add_full), .i_lc_full(lc_full),
		.i_rob_full(rob_full), .i_rob_tail(rob_tail), .i_busy(busy),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_instr_pop(o_instr_pop), .o_add_push(add_push), .o_lc_push(lc_push),
		.o_exe_param(exe_param),
		.o_rob_alloc_valid(rob_alloc_valid), .o_rob_alloc(rob_alloc),
		.o_rs1(rs1), .o_rs2(rs2)
	);

	issue_fifo #(.DP(ISSUE_DP)) add_issue_fifo (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_push(add_push), .i_data(exe_param), .i_pop(add_pop),
		.o_data(add_head), .o_full(add_full), .o_empty(add_empty)
	);

	issue_fifo #(.DP(ISSUE_DP)) lc_issue_fifo (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_push(lc_push), .i_data(exe_param), .i_pop(lc_pop),
		.o_data(lc_head), .o_full(lc_full), .o_empty(lc_empty)
	);

	adder_unit u_adder_unit (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_empty(add_empty), .i_param(add_head),
		.o_pop(add_pop), .o_wb(add_wb)
	);

	logcmp_unit u_logcmp_unit (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_empty(lc_empty), .i_param(lc_head),
		.o_pop(lc_pop), .o_wb(lc_wb)
	);

	writeback_commit u_writeback_commit (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_rob_alloc_valid(rob_alloc_valid), .i_rob_alloc(rob_alloc),
		.i_rs1(rs1), .i_rs2(rs2),
		.i_add_wb(add_wb), .i_lc_wb(lc_wb),
		.o_rob_full(rob_full), .o_rob_tail(rob_tail),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_busy(busy),
		.o_commit_valid(o_commit_valid), .o_commit(o_commit)
	);

endmodule

//--- verification/tb_back_end.sv
`timescale 1ns/1ns

module tb_back_end import backend_pkg::*; ();

	localparam int DRAIN_LIMIT = 2000;

	logic         CLK = 1'b0;
	logic         i_rst_n = 1'b0;
	micro_instr_t i_instr = '0;
	logic         i_instr_empty = 1'b1;
	logic         o_instr_pop;
	logic         o_commit_valid;
	commit_t      o_commit;

	// program and expected commits, consumed by index
	micro_instr_t instr_q[$];
	commit_t      exp_q[$];
	int           fetch_idx = 0;
	int           chk_idx = 0;
	int           commit_cnt = 0;
	commit_t      exp_head;
	logic         exp_any;

	logic [XLEN-1:0] ref_regs [2**AREG_AW];
	op_e             lc_ops [5] = '{OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU};

	string test_name = "reset";
	int    chk_errs = 0;
	int    count_errs = 0;
	int    err0;
	int    cnt0;
	int    sent;
	int    n_tests = 0;
	int    n_failed = 0;
	logic  timed_out = 1'b0;

	back_end UUT (
		.CLK(CLK), .i_rst_n(i_rst_n),
		.i_instr(i_instr), .i_instr_empty(i_instr_empty), .o_instr_pop(o_instr_pop),
		.o_commit_valid(o_commit_valid), .o_commit(o_commit)
	);

	always #2 CLK = ~CLK;

	// instruction fifo model, next word shows up the cycle after a pop
	always @(posedge CLK) begin
		int nxt;
		nxt = fetch_idx + int'(o_instr_pop);
		fetch_idx <= nxt;
		i_instr_empty <= (nxt >= instr_q.size());
		if (nxt < instr_q.size()) begin
			i_instr <= instr_q[nxt];
		end
		if (o_commit_valid) begin
			commit_cnt++;
			if (chk_idx < exp_q.size()) begin
				chk_idx++;
			end
		end
		exp_any = (chk_idx < exp_q.size());
		if (exp_any) begin
			exp_head = exp_q[chk_idx];
		end
	end

	a_idle_no_pop: assert property (@(negedge CLK) disable iff (!i_rst_n)
		i_instr_empty |-> !o_instr_pop)
	else begin
		$display("instruction popped from an empty fifo in test %s", test_name);
		chk_errs++;
	end

	a_commit_known: assert property (@(negedge CLK) disable iff (!i_rst_n)
		o_commit_valid |-> exp_any)
	else begin
		$display("commit with nothing outstanding in test %s", test_name);
		chk_errs++;
	end

	a_commit_value: assert property (@(negedge CLK) disable iff (!i_rst_n)
		(o_commit_valid && exp_any) |-> (o_commit == exp_head))
	else begin
		$display("ERR %s expected rd=%0d data=%h actual rd=%0d data=%h",
			test_name, exp_head.rd, exp_head.data, o_commit.rd, o_commit.data);
		chk_errs++;
	end

	function automatic micro_instr_t make_instr(input op_e op, input int rd, input int rs1,
		input int rs2, input logic use_imm, input logic [15:0] imm);
		micro_instr_t ins;
		ins.op      = op;
		ins.rd      = AREG_AW'(rd);
		ins.rs1     = AREG_AW'(rs1);
		ins.rs2     = AREG_AW'(rs2);
		ins.use_imm = use_imm;
		ins.imm     = imm;
		return ins;
	endfunction

	// sequential reference, x0 stays zero because it is never written
	function automatic logic [XLEN-1:0] ref_exec(input micro_instr_t ins);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		a = ref_regs[ins.rs1];
		b = ins.use_imm ? {{(XLEN-16){ins.imm[15]}}, ins.imm} : ref_regs[ins.rs2];
		case (ins.op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			OP_SLTU: return {{(XLEN-1){1'b0}}, a < b};
			default: return '0;
		endcase
	endfunction

	task automatic send(input micro_instr_t ins);
		commit_t c;
		c.rd   = ins.rd;
		c.data = ref_exec(ins);
		if (ins.rd != '0) begin
			ref_regs[ins.rd] = c.data;
		end
		instr_q.push_back(ins);
		exp_q.push_back(c);
		sent++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err0      = chk_errs + count_errs;
		cnt0      = commit_cnt;
		sent      = 0;
		// queue updates land between edges
		@(posedge CLK);
		#1;
	endtask

	task automatic end_test();
		int n;
		n = 0;
		while (chk_idx < exp_q.size() && n < DRAIN_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (chk_idx < exp_q.size()) begin
			$display("timeout in test %s, %0d commits never arrived",
				test_name, exp_q.size() - chk_idx);
			timed_out = 1'b1;
		end
		// room for a late duplicate commit
		repeat (8) @(negedge CLK);
		assert (commit_cnt - cnt0 == sent) else begin
			$display("test %s sent %0d instructions but saw %0d commits",
				test_name, sent, commit_cnt - cnt0);
			count_errs++;
		end
		n_tests++;
		if (timed_out || chk_errs + count_errs != err0) begin
			n_failed++;
			$display("test %-8s FAIL", test_name);
		end else begin
			$display("test %-8s ok, %0d commits", test_name, sent);
		end
	endtask

	task automatic reset_test();
		begin_test("reset");
		repeat (6) @(posedge CLK);
		#1;
		// registers never written yet, all sources read zero
		send(make_instr(OP_ADD, 1, 2, 3, 1'b0, 16'h0));
		send(make_instr(OP_OR, 4, 5, 6, 1'b0, 16'h0));
		send(make_instr(OP_SLTU, 7, 8, 9, 1'b0, 16'h0));
		send(make_instr(OP_SUB, 10, 11, 12, 1'b0, 16'h0));
		end_test();
	endtask

	task automatic adder_test();
		begin_test("adder");
		for (int i = 0; i < 40; i++) begin
			send(make_instr(($urandom_range(1, 0) == 1) ? OP_SUB : OP_ADD,
				$urandom_range(31, 1), $urandom_range(31, 0), $urandom_range(31, 0),
				1'($urandom), 16'($urandom)));
		end
		end_test();
	endtask

	task automatic logcmp_test();
		begin_test("logcmp");
		for (int i = 1; i <= 7; i++) begin
			send(make_instr(OP_ADD, i, 0, 0, 1'b1, 16'($urandom)));
		end
		send(make_instr(OP_ADD, 8, 0, 0, 1'b1, 16'h8000));
		send(make_instr(OP_SUB, 9, 0, 1, 1'b0, 16'h0));
		for (int i = 0; i < 40; i++) begin
			send(make_instr(lc_ops[$urandom_range(4, 0)], $urandom_range(20, 10),
				$urandom_range(9, 0), $urandom_range(9, 0), 1'($urandom), 16'($urandom)));
		end
		end_test();
	endtask

	// slow logic/compare op ahead of independent adds
	task automatic order_test();
		begin_test("order");
		for (int i = 0; i < 6; i++) begin
			send(make_instr(lc_ops[$urandom_range(4, 0)], 10, 1, 2, 1'b0, 16'h0));
			send(make_instr(OP_ADD, 11, 3, 0, 1'b1, 16'($urandom)));
			send(make_instr(OP_SUB, 12, 4, 5, 1'b0, 16'h0));
			send(make_instr(OP_ADD, 13, 6, 0, 1'b1, 16'($urandom)));
		end
		end_test();
	endtask

	task automatic hazard_test();
		begin_test("hazard");
		for (int i = 0; i < 5; i++) begin
			send(make_instr(OP_ADD, 5, 5, 0, 1'b1, 16'd1));
		end
		send(make_instr(OP_ADD, 0, 5, 0, 1'b1, 16'h1234));
		send(make_instr(OP_OR, 6, 0, 0, 1'b0, 16'h0));
		send(make_instr(OP_XOR, 6, 6, 5, 1'b0, 16'h0));
		for (int i = 0; i < 30; i++) begin
			send(make_instr(($urandom_range(2, 0) == 0) ? lc_ops[$urandom_range(4, 0)] : OP_SUB,
				$urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(3, 0),
				1'($urandom), 16'($urandom)));
		end
		end_test();
	endtask

	task automatic burst_test();
		begin_test("burst");
		for (int i = 0; i < 2 * ROB_DEPTH; i++) begin
			send(make_instr((i % 3 == 0) ? lc_ops[$urandom_range(4, 0)] : OP_ADD,
				i + 1, 20 + (i % 8), 27 - (i % 8), 1'($urandom), 16'($urandom)));
		end
		end_test();
	endtask

	task automatic end_run();
		$display("tests run %0d, failed %0d, check errors %0d",
			n_tests, n_failed, chk_errs + count_errs);
		if (n_failed == 0 && chk_errs + count_errs == 0 && !timed_out) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(34));
		foreach (ref_regs[i]) begin
			ref_regs[i] = '0;
		end
		repeat (2) @(posedge CLK);
		i_rst_n <= 1'b1;
		reset_test();
		if (!timed_out) adder_test();
		if (!timed_out) logcmp_test();
		if (!timed_out) order_test();
		if (!timed_out) hazard_test();
		if (!timed_out) burst_test();
		end_run();
	end

endmodule

//--- sim.f
rtl/backend_pkg.sv
rtl/dispatch.sv
rtl/issue_fifo.sv
rtl/adder_unit.sv
rtl/logcmp_unit.sv
rtl/writeback_commit.sv
rtl/back_end.sv
verification/tb_back_end.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_back_end -f sim.f

out=$(./obj_dir/Vtb_back_end 2>&1) || true
printf '%s\n' "$out"

# pass only when the testbench reports it
printf '%s\n' "$out" | grep -qx "All tests passed"
